/* Bender.yml */
package:
  name: tank_arena

sources:
  # design, package first
  - files:
      - src/tank_pkg.sv
      - src/game_tick.sv
      - src/enemy_tank_ai.sv
      - src/enemy_bullet.sv
      - src/tank_arena.sv

  # bound assertions and testbench
  - target: test
    files:
      - verification/tank_arena_sva.sv
      - verification/tb_tank_arena.sv

/* project.f */
src/tank_pkg.sv
src/game_tick.sv
src/enemy_tank_ai.sv
src/enemy_bullet.sv
src/tank_arena.sv
verification/tank_arena_sva.sv
verification/tb_tank_arena.sv

/* src/enemy_bullet.sv */
// --------------------
// enemy bullet
// single bullet launched from the tank cell, one cell per
// bullet tick, retired at the arena edge
// --------------------

`timescale 1ns/1ps

module enemy_bullet
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          enable,
	input  logic                          bullet_tick,
	input  logic                          fire,        // dropped while in flight
	input  tank_pkg::dir_e                fire_dir,
	input  logic [tank_pkg::COORD_W-1:0]  tank_x,
	input  logic [tank_pkg::COORD_W-1:0]  tank_y,
	output logic                          ebul_active,
	output logic [tank_pkg::COORD_W-1:0]  ebul_x,
	output logic [tank_pkg::COORD_W-1:0]  ebul_y
);

	tank_pkg::dir_e dir_q;    // flight direction
	logic           at_edge;  // next step would leave the arena

	always_comb
	begin
		case (dir_q)
			tank_pkg::DIR_UP:   at_edge = (ebul_y == '0);
			tank_pkg::DIR_DOWN: at_edge = (ebul_y == tank_pkg::Y_MAX);
			tank_pkg::DIR_LEFT: at_edge = (ebul_x == '0);
			default:            at_edge = (ebul_x == tank_pkg::X_MAX);
		endcase
	end

	// --------------------
	// flight control
	always_ff @(posedge clk)
	begin
		if (!rst_n || !enable)
			ebul_active <= 1'b0;
		else if (!ebul_active)
			ebul_active <= fire;                 // accept only when idle
		else if (bullet_tick && at_edge)
			ebul_active <= 1'b0;                 // flew off the arena
	end

	// --------------------
	// position and direction
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ebul_x <= '0;
			ebul_y <= '0;
			dir_q  <= tank_pkg::DIR_UP;
		end
		else if (!ebul_active && fire)
		begin
			ebul_x <= tank_x;   // launch cell
			ebul_y <= tank_y;
			dir_q  <= fire_dir;
		end
		else if (ebul_active && bullet_tick && !at_edge)
		begin
			case (dir_q)
				tank_pkg::DIR_UP:   ebul_y <= ebul_y - 1'b1;
				tank_pkg::DIR_DOWN: ebul_y <= ebul_y + 1'b1;
				tank_pkg::DIR_LEFT: ebul_x <= ebul_x - 1'b1;
				default:            ebul_x <= ebul_x + 1'b1;
			endcase
		end
	end

endmodule

/* src/enemy_tank_ai.sv */
// --------------------
// enemy tank
// spawn at a corner, chase the player one cell per move tick,
// request a shot when lined up, detect hits and count kills
// --------------------

`timescale 1ns/1ps

module enemy_tank_ai
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          enable,
	input  logic                          move_tick,
	input  logic                          spawn,
	input  tank_pkg::corner_e             spawn_corner,
	input  logic [tank_pkg::COORD_W-1:0]  player_x,
	input  logic [tank_pkg::COORD_W-1:0]  player_y,
	input  logic                          shot_valid,    // player bullet in flight
	input  logic [tank_pkg::COORD_W-1:0]  shot_x,
	input  logic [tank_pkg::COORD_W-1:0]  shot_y,
	output logic                          tank_alive,
	output logic [tank_pkg::COORD_W-1:0]  tank_x,
	output logic [tank_pkg::COORD_W-1:0]  tank_y,
	output tank_pkg::dir_e                tank_dir,      // last step taken
	output logic [tank_pkg::SCORE_W-1:0]  score,
	output logic                          fire,          // one cycle shot request
	output tank_pkg::dir_e                fire_dir
);

	tank_pkg::tank_state_e state_q;

	// --------------------
	// distance stage, one cycle behind the cells
	logic [tank_pkg::COORD_W-1:0] h_dis;   // |player_x - tank_x|
	logic [tank_pkg::COORD_W-1:0] v_dis;   // |player_y - tank_y|
	logic                         plr_left; // player has smaller x
	logic                         plr_up;   // player has smaller y

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			h_dis    <= '0;
			v_dis    <= '0;
			plr_left <= 1'b0;
			plr_up   <= 1'b0;
		end
		else if (enable)
		begin
			plr_left <= (player_x < tank_x);
			plr_up   <= (player_y < tank_y);
			h_dis    <= (player_x < tank_x) ? tank_x - player_x : player_x - tank_x;
			v_dis    <= (player_y < tank_y) ? tank_y - player_y : player_y - tank_y;
		end
	end

	// --------------------
	// chase rule
	logic           h_zero;
	logic           v_zero;
	logic           on_player;  // same cell, stand still
	logic           aligned;    // same row or column only
	logic           go_horiz;
	logic           step_ok;    // step stays inside the arena
	tank_pkg::dir_e step_dir;

	assign h_zero    = (h_dis == '0);
	assign v_zero    = (v_dis == '0);
	assign on_player = h_zero && v_zero;
	assign aligned   = h_zero ^ v_zero;
	// row aligned, or shorter horizontal gap; ties go vertical
	assign go_horiz  = v_zero || (!h_zero && (h_dis < v_dis));

	always_comb
	begin
		if (go_horiz)
			step_dir = plr_left ? tank_pkg::DIR_LEFT : tank_pkg::DIR_RIGHT;
		else
			step_dir = plr_up ? tank_pkg::DIR_UP : tank_pkg::DIR_DOWN;
	end

	always_comb
	begin
		case (step_dir)
			tank_pkg::DIR_UP:   step_ok = (tank_y != '0);
			tank_pkg::DIR_DOWN: step_ok = (tank_y != tank_pkg::Y_MAX);
			tank_pkg::DIR_LEFT: step_ok = (tank_x != '0);
			default:            step_ok = (tank_x != tank_pkg::X_MAX);
		endcase
	end

	// --------------------
	// spawn corner decode
	logic [tank_pkg::COORD_W-1:0] corner_x;
	logic [tank_pkg::COORD_W-1:0] corner_y;
	tank_pkg::dir_e               corner_dir;  // face into the arena

	always_comb
	begin
		corner_x   = '0;
		corner_y   = '0;
		corner_dir = tank_pkg::DIR_DOWN;
		case (spawn_corner)
			tank_pkg::CORNER_NW: ;
			tank_pkg::CORNER_NE: corner_x = tank_pkg::X_MAX;
			tank_pkg::CORNER_SW:
			begin
				corner_y   = tank_pkg::Y_MAX;
				corner_dir = tank_pkg::DIR_UP;
			end
			default:
			begin
				corner_x   = tank_pkg::X_MAX;
				corner_y   = tank_pkg::Y_MAX;
				corner_dir = tank_pkg::DIR_UP;
			end
		endcase
	end

	// --------------------
	// hit test, player on the tank or shot on tank or a neighbour
	logic x_eq;
	logic y_eq;
	logic x_adj;  // shot one column off, no wrap
	logic y_adj;
	logic hit;

	assign x_eq  = (shot_x == tank_x);
	assign y_eq  = (shot_y == tank_y);
	assign x_adj = ({1'b0, tank_x} + 1'b1 == {1'b0, shot_x}) ||
	               ({1'b0, shot_x} + 1'b1 == {1'b0, tank_x});
	assign y_adj = ({1'b0, tank_y} + 1'b1 == {1'b0, shot_y}) ||
	               ({1'b0, shot_y} + 1'b1 == {1'b0, tank_y});
	assign hit   = tank_alive &&
	               (((player_x == tank_x) && (player_y == tank_y)) ||
	                (shot_valid && ((x_eq && y_eq) || (x_eq && y_adj) || (x_adj && y_eq))));

	assign tank_alive = (state_q == tank_pkg::TANK_ALIVE);

	// --------------------
	// tank state, position and score
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q  <= tank_pkg::TANK_IDLE;
			tank_x   <= '0;
			tank_y   <= '0;
			tank_dir <= tank_pkg::DIR_UP;
			score    <= '0;
			fire     <= 1'b0;
			fire_dir <= tank_pkg::DIR_UP;
		end
		else if (!enable)
		begin
			state_q <= tank_pkg::TANK_IDLE;  // game restart
			score   <= '0;
			fire    <= 1'b0;
		end
		else
		begin
			fire <= 1'b0;  // strobe
			case (state_q)
				tank_pkg::TANK_IDLE:
				begin
					if (spawn)
					begin
						state_q  <= tank_pkg::TANK_ALIVE;
						tank_x   <= corner_x;
						tank_y   <= corner_y;
						tank_dir <= corner_dir;
					end
				end
				default:
				begin
					if (hit)
					begin
						state_q <= tank_pkg::TANK_IDLE;
						score   <= score + 1'b1;  // wraps
					end
					else if (move_tick && !on_player)
					begin
						if (aligned)
						begin
							fire     <= 1'b1;      // lined up, shoot along the line
							fire_dir <= step_dir;
						end
						if (step_ok)
						begin
							tank_dir <= step_dir;
							case (step_dir)
								tank_pkg::DIR_UP:   tank_y <= tank_y - 1'b1;
								tank_pkg::DIR_DOWN: tank_y <= tank_y + 1'b1;
								tank_pkg::DIR_LEFT: tank_x <= tank_x - 1'b1;
								default:            tank_x <= tank_x + 1'b1;
							endcase
						end
					end
				end
			endcase
		end
	end

endmodule

/* src/game_tick.sv */
// --------------------
// game tick generator
// move and bullet enable strobes divided down from clk
// --------------------

`timescale 1ns/1ps

module game_tick
(
	input  logic clk,
	input  logic rst_n,
	input  logic enable,
	output logic move_tick,    // one cycle every MOVE_TICK_CYCLES
	output logic bullet_tick   // one cycle every BULLET_TICK_CYCLES
);

	logic [tank_pkg::MOVE_CNT_W-1:0]   move_cnt;
	logic [tank_pkg::BULLET_CNT_W-1:0] bullet_cnt;

	// counters held at zero while the game is off
	// so a restart begins with a full period
	always_ff @(posedge clk)
	begin
		if (!rst_n || !enable)
		begin
			move_cnt    <= '0;
			bullet_cnt  <= '0;
			move_tick   <= 1'b0;
			bullet_tick <= 1'b0;
		end
		else
		begin
			move_tick   <= (move_cnt == tank_pkg::MOVE_LAST);     // pulse on wrap
			bullet_tick <= (bullet_cnt == tank_pkg::BULLET_LAST);
			move_cnt    <= (move_cnt == tank_pkg::MOVE_LAST) ? '0 : move_cnt + 1'b1;
			bullet_cnt  <= (bullet_cnt == tank_pkg::BULLET_LAST) ? '0 : bullet_cnt + 1'b1;
		end
	end

endmodule

/* src/tank_arena.sv */
// --------------------
// tank arena top
// tick generator, enemy tank and enemy bullet
// --------------------

`timescale 1ns/1ps

module tank_arena
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          enable,       // low restarts the game
	input  logic                          spawn,
	input  tank_pkg::corner_e             spawn_corner,
	input  logic [tank_pkg::COORD_W-1:0]  player_x,
	input  logic [tank_pkg::COORD_W-1:0]  player_y,
	input  logic                          shot_valid,
	input  logic [tank_pkg::COORD_W-1:0]  shot_x,
	input  logic [tank_pkg::COORD_W-1:0]  shot_y,
	output logic                          tank_alive,
	output logic [tank_pkg::COORD_W-1:0]  tank_x,
	output logic [tank_pkg::COORD_W-1:0]  tank_y,
	output tank_pkg::dir_e                tank_dir,
	output logic [tank_pkg::SCORE_W-1:0]  score,
	output logic                          ebul_active,
	output logic [tank_pkg::COORD_W-1:0]  ebul_x,
	output logic [tank_pkg::COORD_W-1:0]  ebul_y
);

	logic           move_tick;
	logic           bullet_tick;
	logic           fire;      // tank to bullet
	tank_pkg::dir_e fire_dir;

	game_tick u_game_tick
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.enable      (enable),
		.move_tick   (move_tick),
		.bullet_tick (bullet_tick)
	);

	enemy_tank_ai u_enemy_tank_ai
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.enable       (enable),
		.move_tick    (move_tick),
		.spawn        (spawn),
		.spawn_corner (spawn_corner),
		.player_x     (player_x),
		.player_y     (player_y),
		.shot_valid   (shot_valid),
		.shot_x       (shot_x),
		.shot_y       (shot_y),
		.tank_alive   (tank_alive),
		.tank_x       (tank_x),
		.tank_y       (tank_y),
		.tank_dir     (tank_dir),
		.score        (score),
		.fire         (fire),
		.fire_dir     (fire_dir)
	);

	// launch cell is the tank cell after its step
	enemy_bullet u_enemy_bullet
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.enable      (enable),
		.bullet_tick (bullet_tick),
		.fire        (fire),
		.fire_dir    (fire_dir),
		.tank_x      (tank_x),
		.tank_y      (tank_y),
		.ebul_active (ebul_active),
		.ebul_x      (ebul_x),
		.ebul_y      (ebul_y)
	);

endmodule

/* src/tank_pkg.sv */
// --------------------
// tank arena package
// arena size, tick periods, coordinate widths and the
// direction, tank state and spawn corner encodings
// --------------------

package tank_pkg;

	// --------------------
	// arena geometry
	localparam int unsigned COORD_W = 5;            // cell coordinate width
	localparam logic [COORD_W-1:0] X_MAX = 5'd24;   // rightmost column
	localparam logic [COORD_W-1:0] Y_MAX = 5'd20;   // bottom row

	// --------------------
	// tick periods in clk cycles
	localparam int unsigned MOVE_TICK_CYCLES   = 8;  // kept short for sim
	localparam int unsigned BULLET_TICK_CYCLES = 4;  // bullet runs at twice tank speed

	localparam int unsigned MOVE_CNT_W   = $clog2(MOVE_TICK_CYCLES);
	localparam int unsigned BULLET_CNT_W = $clog2(BULLET_TICK_CYCLES);

	// terminal counts where the strobes fire
	localparam logic [MOVE_CNT_W-1:0]   MOVE_LAST   = MOVE_CNT_W'(MOVE_TICK_CYCLES - 1);
	localparam logic [BULLET_CNT_W-1:0] BULLET_LAST = BULLET_CNT_W'(BULLET_TICK_CYCLES - 1);

	// score counter, wraps mod 32
	localparam int unsigned SCORE_W = 5;

	// --------------------
	// encodings
	typedef enum logic [1:0]
	{
		DIR_UP    = 2'd0,   // y - 1
		DIR_DOWN  = 2'd1,   // y + 1
		DIR_LEFT  = 2'd2,   // x - 1
		DIR_RIGHT = 2'd3    // x + 1
	} dir_e;

	typedef enum logic
	{
		TANK_IDLE  = 1'b0,
		TANK_ALIVE = 1'b1
	} tank_state_e;

	// spawn corners, bit 0 picks east and bit 1 picks south
	typedef enum logic [1:0]
	{
		CORNER_NW = 2'd0,   // (0,0)
		CORNER_NE = 2'd1,   // (X_MAX,0)
		CORNER_SW = 2'd2,   // (0,Y_MAX)
		CORNER_SE = 2'd3    // (X_MAX,Y_MAX)
	} corner_e;

endpackage

/* verification/tank_arena_sva.sv */
// --------------------
// movement assertions
// bound to the enemy tank and to the enemy bullet, single steps
// on ticks only, cells inside the arena, no appearance without launch
// --------------------

`timescale 1ns/1ps

module tank_arena_sva
(
	input logic                         clk,
	input logic                         rst_n,
	input logic                         tick,    // move or bullet tick
	input logic                         launch,  // spawn or fire
	input logic                         valid,   // tank alive or bullet in flight
	input logic [tank_pkg::COORD_W-1:0] x,
	input logic [tank_pkg::COORD_W-1:0] y
);

	int unsigned fail_cnt = 0;  // failed assertions so far

	// --------------------
	a_in_bounds: assert property (@(posedge clk) disable iff (!rst_n)
		valid |-> (x <= tank_pkg::X_MAX) && (y <= tank_pkg::Y_MAX))
		else
		begin
			$error("cell outside the arena");
			fail_cnt++;
		end

	// one coordinate, one cell
	a_one_step: assert property (@(posedge clk) disable iff (!rst_n)
		(valid && $past(valid)) |->
			((x == $past(x)) && ((y == $past(y)) || (y == $past(y) + 1) || (y + 1 == $past(y)))) ||
			((y == $past(y)) && ((x == $past(x) + 1) || (x + 1 == $past(x)))))
		else
		begin
			$error("moved more than one cell");
			fail_cnt++;
		end

	a_tick_only: assert property (@(posedge clk) disable iff (!rst_n)
		(valid && $past(valid) && !$past(tick)) |-> (x == $past(x)) && (y == $past(y)))
		else
		begin
			$error("moved without a tick");
			fail_cnt++;
		end

	// single object, only a launch brings it in
	a_no_launch: assert property (@(posedge clk) disable iff (!rst_n)
		(!valid && !launch) |=> !valid)
		else
		begin
			$error("appeared without a launch");
			fail_cnt++;
		end

endmodule

bind enemy_tank_ai tank_arena_sva u_tank_sva
	(.clk(clk), .rst_n(rst_n), .tick(move_tick), .launch(spawn), .valid(tank_alive),
	 .x(tank_x), .y(tank_y));

bind enemy_bullet tank_arena_sva u_bullet_sva
	(.clk(clk), .rst_n(rst_n), .tick(bullet_tick), .launch(fire), .valid(ebul_active),
	 .x(ebul_x), .y(ebul_y));

/* verification/tb_tank_arena.sv */
// --------------------
// tank arena testbench
// random play against a cycle model of the enemy tank and bullet
// --------------------

`timescale 1ns/1ps

module tb_tank_arena;

	logic                                clk;
	logic                                rst_n;
	logic                                enable;
	logic                                spawn;
	tank_pkg::corner_e                   spawn_corner;
	logic [tank_pkg::COORD_W-1:0]        player_x;
	logic [tank_pkg::COORD_W-1:0]        player_y;
	logic                                shot_valid;
	logic [tank_pkg::COORD_W-1:0]        shot_x;
	logic [tank_pkg::COORD_W-1:0]        shot_y;
	logic                                tank_alive;
	logic [tank_pkg::COORD_W-1:0]        tank_x;
	logic [tank_pkg::COORD_W-1:0]        tank_y;
	tank_pkg::dir_e                      tank_dir;
	logic [tank_pkg::SCORE_W-1:0]        score;
	logic                                ebul_active;
	logic [tank_pkg::COORD_W-1:0]        ebul_x;
	logic [tank_pkg::COORD_W-1:0]        ebul_y;

	// --------------------
	// reference model state
	int                           m_mcnt;     // tick counters
	int                           m_bcnt;
	logic                         m_mtick;
	logic                         m_btick;
	int                           m_hd;       // registered distances
	int                           m_vd;
	logic                         m_left;
	logic                         m_up;
	tank_pkg::tank_state_e        m_state;
	logic [tank_pkg::COORD_W-1:0] m_tx;
	logic [tank_pkg::COORD_W-1:0] m_ty;
	tank_pkg::dir_e               m_dir;
	logic [tank_pkg::SCORE_W-1:0] m_score;
	logic                         m_fire;
	tank_pkg::dir_e               m_fdir;
	logic                         m_bact;     // bullet in flight
	logic [tank_pkg::COORD_W-1:0] m_bx;
	logic [tank_pkg::COORD_W-1:0] m_by;
	tank_pkg::dir_e               m_bdir;

	integer seed;
	int     rst_hold;    // reset cycles still to go
	int     err_cnt;
	int     restarts;    // enable drops during a live game
	int     launches;
	int     blocked;     // fire while a bullet flies
	logic   wrap_seen;   // score went 31 -> 0
	logic   hunt;        // shots biased onto the tank

	tank_arena u_tank_arena (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------
	// helpers
	function automatic int pick(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic int gap(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	function automatic logic [tank_pkg::COORD_W-1:0] near(input int c, input int hi);
		int v;
		v = c + pick(3) - 1;   // one cell either way
		if (v < 0)
			v = 0;
		if (v > hi)
			v = hi;
		return v[tank_pkg::COORD_W-1:0];
	endfunction

	function automatic bit can_step(input tank_pkg::dir_e d,
		input logic [tank_pkg::COORD_W-1:0] x, input logic [tank_pkg::COORD_W-1:0] y);
		case (d)
			tank_pkg::DIR_UP:   return y > 0;
			tank_pkg::DIR_DOWN: return y < tank_pkg::Y_MAX;
			tank_pkg::DIR_LEFT: return x > 0;
			default:            return x < tank_pkg::X_MAX;
		endcase
	endfunction

	task automatic advance(input tank_pkg::dir_e d,
		inout logic [tank_pkg::COORD_W-1:0] x, inout logic [tank_pkg::COORD_W-1:0] y);
		case (d)
			tank_pkg::DIR_UP:   y = y - 1'b1;
			tank_pkg::DIR_DOWN: y = y + 1'b1;
			tank_pkg::DIR_LEFT: x = x - 1'b1;
			default:            x = x + 1'b1;
		endcase
	endtask

	// --------------------
	// one clock edge of the model, inputs as sampled by the DUT
	task automatic model_step();
		tank_pkg::tank_state_e        st;
		logic [tank_pkg::COORD_W-1:0] tx;
		logic [tank_pkg::COORD_W-1:0] ty;
		logic                         fire_q;
		tank_pkg::dir_e               fdir_q;
		logic                         hit;
		tank_pkg::dir_e               d;
		if (!rst_n)
		begin
			m_mcnt = 0; 
			m_bcnt = 0;
			m_mtick = 1'b0;
			m_btick = 1'b0;
			m_hd = 0;
			m_vd = 0;
			m_left = 1'b0;
			m_up = 1'b0;
			m_state = tank_pkg::TANK_IDLE;
			m_tx = '0;
			m_ty = '0;
			m_dir = tank_pkg::DIR_UP;
			m_score = '0;
			m_fire = 1'b0;
			m_fdir = tank_pkg::DIR_UP;
			m_bact = 1'b0;
			m_bx = '0;
			m_by = '0;
		end
		else
		begin
			st = m_state;
			tx = m_tx;
			ty = m_ty;
			fire_q = m_fire;
			fdir_q = m_fdir;
			hit = (st == tank_pkg::TANK_ALIVE) &&
			      (((player_x == tx) && (player_y == ty)) ||
			       (shot_valid && (((shot_x == tx) && (gap(shot_y, ty) <= 1)) ||
			                       ((shot_y == ty) && (gap(shot_x, tx) == 1)))));
			// bullet, launch from the cell the tank holds now
			if (!enable)
				m_bact = 1'b0;
			else if (!m_bact)
			begin
				if (fire_q)
				begin
					m_bact = 1'b1;
					m_bx = tx;
					m_by = ty;
					m_bdir = fdir_q;
					launches++;
				end
			end
			else
			begin
				if (fire_q)
					blocked++;
				if (m_btick && !can_step(m_bdir, m_bx, m_by))
					m_bact = 1'b0;   // off the edge
				else if (m_btick)
					advance(m_bdir, m_bx, m_by);
			end
			// tank
			if (!enable)
			begin
				if ((st == tank_pkg::TANK_ALIVE) || (m_score != '0))
					restarts++;
				m_state = tank_pkg::TANK_IDLE;
				m_score = '0;
				m_fire = 1'b0;
			end
			else
			begin
				m_fire = 1'b0;
				if (st == tank_pkg::TANK_IDLE)
				begin
					if (spawn)
					begin
						m_state = tank_pkg::TANK_ALIVE;
						m_tx = ((spawn_corner == tank_pkg::CORNER_NE) ||
						        (spawn_corner == tank_pkg::CORNER_SE)) ? tank_pkg::X_MAX : '0;
						m_ty = ((spawn_corner == tank_pkg::CORNER_SW) ||
						        (spawn_corner == tank_pkg::CORNER_SE)) ? tank_pkg::Y_MAX : '0;
						if ((spawn_corner == tank_pkg::CORNER_NW) ||
						    (spawn_corner == tank_pkg::CORNER_NE))
							m_dir = tank_pkg::DIR_DOWN;   // north corners face down
						else
							m_dir = tank_pkg::DIR_UP;
					end
				end
				else if (hit)
				begin
					m_state = tank_pkg::TANK_IDLE;
					if (m_score == 5'd31)
						wrap_seen = 1'b1;
					m_score = m_score + 1'b1;
				end
				else if (m_mtick && !((m_hd == 0) && (m_vd == 0)))
				begin
					if (m_hd == 0)
						d = m_up ? tank_pkg::DIR_UP : tank_pkg::DIR_DOWN;          // same column
					else if (m_vd == 0)
						d = m_left ? tank_pkg::DIR_LEFT : tank_pkg::DIR_RIGHT;     // same row
					else if (m_hd < m_vd)
						d = m_left ? tank_pkg::DIR_LEFT : tank_pkg::DIR_RIGHT;     // shorter gap
					else
						d = m_up ? tank_pkg::DIR_UP : tank_pkg::DIR_DOWN;          // ties vertical
					if ((m_hd == 0) || (m_vd == 0))
					begin
						m_fire = 1'b1;   // lined up
						m_fdir = d;
					end
					if (can_step(d, tx, ty))
					begin
						m_dir = d;
						advance(d, m_tx, m_ty);
					end
				end
			end
			// distance stage
			if (enable)
			begin
				m_left = (player_x < tx);
				m_up = (player_y < ty);
				m_hd = gap(player_x, tx);
				m_vd = gap(player_y, ty);
			end
			// tick strobes
			if (!enable)
			begin
				m_mcnt = 0;
				m_bcnt = 0;
				m_mtick = 1'b0;
				m_btick = 1'b0;
			end
			else
			begin
				m_mtick = (m_mcnt == tank_pkg::MOVE_TICK_CYCLES - 1);
				m_btick = (m_bcnt == tank_pkg::BULLET_TICK_CYCLES - 1);
				m_mcnt = (m_mcnt + 1) % tank_pkg::MOVE_TICK_CYCLES;
				m_bcnt = (m_bcnt + 1) % tank_pkg::BULLET_TICK_CYCLES;
			end
		end
	endtask

	// --------------------
	// random stimulus
	task automatic drive_inputs();
		int r;
		if (pick(64) == 0)
		begin
			r = pick(tank_pkg::X_MAX + 1);   // player moves rarely
			player_x <= r[tank_pkg::COORD_W-1:0];
			r = pick(tank_pkg::Y_MAX + 1);
			player_y <= r[tank_pkg::COORD_W-1:0];
		end
		shot_valid <= (pick(hunt ? 3 : 16) == 0);
		if (pick(4) != 0)
		begin
			shot_x <= near(m_tx, tank_pkg::X_MAX);   // around the tank
			shot_y <= near(m_ty, tank_pkg::Y_MAX);
		end
		else
		begin
			r = pick(tank_pkg::X_MAX + 1);
			shot_x <= r[tank_pkg::COORD_W-1:0];
			r = pick(tank_pkg::Y_MAX + 1);
			shot_y <= r[tank_pkg::COORD_W-1:0];
		end
		spawn <= (pick(8) == 0);
		spawn_corner <= tank_pkg::corner_e'(pick(4));
		if (hunt)
			enable <= 1'b1;
		else if (enable)
			enable <= (pick(500) != 0);   // rare restart
		else
			enable <= (pick(4) == 0);
	endtask

	// --------------------
	// compare tasks
	task automatic report_mismatch();
		$display("test failed");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic check_coord(input string name, input logic [tank_pkg::COORD_W-1:0] exp,
		input logic [tank_pkg::COORD_W-1:0] act);
		if (act !== exp)
		begin
			$display("error at %0t: %s expected %0d actual %0d", $time, name, exp, act);
			report_mismatch();
		end
	endtask

	task automatic check_dir(input string name, input tank_pkg::dir_e exp,
		input tank_pkg::dir_e act);
		if (act !== exp)
		begin
			$display("error at %0t: %s expected %s actual %s", $time, name, exp.name(),
				act.name());
			report_mismatch();
		end
	endtask

	task automatic check_state(input tank_pkg::tank_state_e exp, input logic act);
		if (act !== (exp == tank_pkg::TANK_ALIVE))
		begin
			$display("error at %0t: tank_alive expected %0b (%s) actual %0b", $time,
				exp == tank_pkg::TANK_ALIVE, exp.name(), act);
			report_mismatch();
		end
	endtask

	task automatic check_score(input logic [tank_pkg::SCORE_W-1:0] exp,
		input logic [tank_pkg::SCORE_W-1:0] act);
		if (act !== exp)
		begin
			$display("error at %0t: score expected %0d actual %0d", $time, exp, act);
			report_mismatch();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("error at %0t: %s expected %0b actual %0b", $time, name, exp, act);
			report_mismatch();
		end
	endtask

	// bound movement rules on the tank and the bullet
	task automatic check_assertions();
		if ((u_tank_arena.u_enemy_tank_ai.u_tank_sva.fail_cnt != 0) ||
		    (u_tank_arena.u_enemy_bullet.u_bullet_sva.fail_cnt != 0))
		begin
			$display("at %0t a movement assertion on the tank or the bullet failed", $time);
			report_mismatch();
		end
	endtask

	task automatic compare_all();
		check_assertions();
		check_state(m_state, tank_alive);
		check_coord("tank_x", m_tx, tank_x);
		check_coord("tank_y", m_ty, tank_y);
		check_dir("tank_dir", m_dir, tank_dir);
		check_score(m_score, score);
		check_flag("ebul_active", m_bact, ebul_active);
		if (m_bact)
		begin
			check_coord("ebul_x", m_bx, ebul_x);   // cell only meaningful in flight
			check_coord("ebul_y", m_by, ebul_y);
		end
	endtask

	// model on the edge, new inputs, compare at the falling edge
	task automatic tick_cycle();
		@(posedge clk);
		model_step();
		if (rst_hold > 0)
		begin
			rst_hold--;
			if (rst_hold == 0)
				rst_n <= 1'b1;
		end
		else
			drive_inputs();
		@(negedge clk);
		compare_all();
	endtask

	task automatic note_gap(input string msg);
		$display("%s", msg);
		err_cnt++;
	endtask

	// --------------------
	// main sequence
	initial
	begin
		int n;
		seed = 52;
		rst_hold = 5;
		err_cnt = 0;
		restarts = 0;
		launches = 0;
		blocked = 0;
		wrap_seen = 1'b0;
		hunt = 1'b0;
		rst_n = 1'b0;
		enable = 1'b0;
		spawn = 1'b0;
		spawn_corner = tank_pkg::CORNER_NW;
		player_x = 5'd12;
		player_y = 5'd10;
		shot_valid = 1'b0;
		shot_x = '0;
		shot_y = '0;
		repeat (4005) tick_cycle();   // reset then free play
		hunt = 1'b1;
		n = 0;
		while (!wrap_seen && (n < 4000))
		begin
			tick_cycle();
			n++;
		end
		if (!wrap_seen)
		begin
			$display("timeout: the score did not wrap past 31 within 4000 cycles");
			$display("test failed");
			$fatal(1, "timeout");
		end
		if (restarts == 0)
			note_gap("enable never dropped while a game was running");
		if (launches == 0)
			note_gap("no enemy bullet was launched");
		if (blocked == 0)
			note_gap("no fire request arrived while a bullet was in flight");
		if (err_cnt == 0)
		begin
			$display("test passed");
			$finish;
		end
		else
		begin
			$display("test failed");
			$fatal(1, "scenario coverage incomplete");
		end
	end

endmodule
